/* flist.f */
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/bypass_if.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/hazard_unit.sv
hw/branch_unit.sv
hw/id_stage.sv
tests/tb_id_stage.sv

/* hw/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
    input  isa_pkg::br_kind_t br_kind,
    input  pipe_pkg::word_t   rj_value,
    input  pipe_pkg::word_t   rkd_value,
    input  pipe_pkg::word_t   pc,
    input  pipe_pkg::word_t   imm_offs,
    output logic              cond_taken,
    output pipe_pkg::word_t   target
);
    import isa_pkg::*;

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = rj_value == rkd_value;
    assign lt  = $signed(rj_value) < $signed(rkd_value);
    assign ltu = rj_value < rkd_value;

    always_comb begin
        case (br_kind)
            b, bl, jirl: cond_taken = 1'b1;
            beq:         cond_taken = eq;
            bne:         cond_taken = !eq;
            blt:         cond_taken = lt;
            bge:         cond_taken = !lt;
            bltu:        cond_taken = ltu;
            bgeu:        cond_taken = !ltu;
            default:     cond_taken = 1'b0;
        endcase
    end

    assign target = ((br_kind == jirl) ? rj_value : pc) + imm_offs;  // jirl is register relative

endmodule

/* hw/bypass_if.sv */
`timescale 1ns/1ps

interface bypass_if;
    import pipe_pkg::*;

    logic      we;     // stage holds an instruction that writes a register
    reg_addr_t waddr;
    word_t     wdata;
    logic      ready;  // wdata is final, low while a load is in flight

    modport src (output we, output waddr, output wdata, output ready);
    modport dst (input we, input waddr, input wdata, input ready);
endinterface

/* hw/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  pipe_pkg::reg_addr_t raddr1,
    input  pipe_pkg::reg_addr_t raddr2,
    input  logic                need_r1,
    input  logic                need_r2,
    input  pipe_pkg::word_t     rf_rdata1,
    input  pipe_pkg::word_t     rf_rdata2,
    bypass_if.dst               ex_bus,
    bypass_if.dst               mem_bus,
    input  logic                wb_we,
    input  pipe_pkg::reg_addr_t wb_waddr,
    input  pipe_pkg::word_t     wb_wdata,
    output pipe_pkg::word_t     rj_value,
    output pipe_pkg::word_t     rkd_value,
    output logic                stall
);
    import pipe_pkg::*;

    logic ex_hit1, ex_hit2;
    logic mem_hit1, mem_hit2;
    logic wb_hit1, wb_hit2;

    // r0 never conflicts, its value is fixed
    function automatic logic hits(input logic need, input reg_addr_t src,
                                  input logic we, input reg_addr_t waddr);
        return need && src != '0 && we && src == waddr;
    endfunction

    assign ex_hit1  = hits(need_r1, raddr1, ex_bus.we, ex_bus.waddr);
    assign ex_hit2  = hits(need_r2, raddr2, ex_bus.we, ex_bus.waddr);
    assign mem_hit1 = hits(need_r1, raddr1, mem_bus.we, mem_bus.waddr);
    assign mem_hit2 = hits(need_r2, raddr2, mem_bus.we, mem_bus.waddr);
    assign wb_hit1  = hits(need_r1, raddr1, wb_we, wb_waddr);
    assign wb_hit2  = hits(need_r2, raddr2, wb_we, wb_waddr);

    // youngest writer wins
    assign rj_value  = ex_hit1  ? ex_bus.wdata  :
                       mem_hit1 ? mem_bus.wdata :
                       wb_hit1  ? wb_wdata      : rf_rdata1;
    assign rkd_value = ex_hit2  ? ex_bus.wdata  :
                       mem_hit2 ? mem_bus.wdata :
                       wb_hit2  ? wb_wdata      : rf_rdata2;

    assign stall = ((ex_hit1 | ex_hit2) & ~ex_bus.ready)
                 | ((mem_hit1 | mem_hit2) & ~mem_bus.ready);  // load result not back yet

endmodule

/* hw/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
    input  logic                clk,
    input  logic                resetn,
    input  logic                if_valid,
    input  isa_pkg::inst_t      if_inst,
    input  pipe_pkg::word_t     if_pc,
    output logic                id_allowin,
    output logic                ex_valid,
    input  logic                ex_allowin,
    output pipe_pkg::alu_op_t   ex_alu_op,
    output pipe_pkg::word_t     ex_alu_src1,
    output pipe_pkg::word_t     ex_alu_src2,
    output pipe_pkg::word_t     ex_rkd_value,
    output logic                ex_rf_we,
    output pipe_pkg::reg_addr_t ex_rf_waddr,
    output logic                ex_res_from_mem,
    output logic                ex_mem_we,
    output pipe_pkg::word_t     ex_pc,
    output logic                br_taken,
    output pipe_pkg::word_t     br_target,
    input  logic                fwd_ex_we,
    input  pipe_pkg::reg_addr_t fwd_ex_waddr,
    input  pipe_pkg::word_t     fwd_ex_wdata,
    input  logic                fwd_ex_ready,
    input  logic                fwd_mem_we,
    input  pipe_pkg::reg_addr_t fwd_mem_waddr,
    input  pipe_pkg::word_t     fwd_mem_wdata,
    input  logic                fwd_mem_ready,
    input  logic                wb_we,
    input  pipe_pkg::reg_addr_t wb_waddr,
    input  pipe_pkg::word_t     wb_wdata,
    input  logic                flush
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic      id_valid;
    inst_t     id_inst;
    word_t     id_pc;
    alu_op_t   alu_op;
    br_kind_t  br_kind;
    word_t     imm;
    word_t     br_offs;
    logic      src1_is_pc, src2_is_imm;
    reg_addr_t raddr1, raddr2, dest;
    logic      need_r1, need_r2;
    logic      gr_we, res_from_mem, mem_we;
    word_t     rf_rdata1, rf_rdata2;
    word_t     rj_value, rkd_value;
    logic      stall, cond_taken, id_leave;

    bypass_if ex_bus ();
    bypass_if mem_bus ();

    assign ex_bus.we     = fwd_ex_we;
    assign ex_bus.waddr  = fwd_ex_waddr;
    assign ex_bus.wdata  = fwd_ex_wdata;
    assign ex_bus.ready  = fwd_ex_ready;
    assign mem_bus.we    = fwd_mem_we;
    assign mem_bus.waddr = fwd_mem_waddr;
    assign mem_bus.wdata = fwd_mem_wdata;
    assign mem_bus.ready = fwd_mem_ready;

    assign ex_valid   = id_valid & ~stall;
    assign id_leave   = ex_valid & ex_allowin;
    assign id_allowin = ~id_valid | id_leave;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (flush || br_taken) begin
            id_valid <= 1'b0;  // drop the wrong-path fetch
        end else if (id_allowin) begin
            id_valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && id_allowin) begin
            id_inst <= if_inst;
            id_pc   <= if_pc;
        end
    end

    inst_decoder inst_decoder_i (
        .inst         (id_inst),
        .alu_op       (alu_op),
        .br_kind      (br_kind),
        .imm          (imm),
        .src1_is_pc   (src1_is_pc),
        .src2_is_imm  (src2_is_imm),
        .raddr1       (raddr1),
        .raddr2       (raddr2),
        .need_r1      (need_r1),
        .need_r2      (need_r2),
        .dest         (dest),
        .gr_we        (gr_we),
        .res_from_mem (res_from_mem),
        .mem_we       (mem_we)
    );

    reg_file reg_file_i (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .we     (wb_we),
        .waddr  (wb_waddr),
        .wdata  (wb_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    hazard_unit hazard_unit_i (
        .raddr1    (raddr1),
        .raddr2    (raddr2),
        .need_r1   (need_r1),
        .need_r2   (need_r2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .ex_bus    (ex_bus),
        .mem_bus   (mem_bus),
        .wb_we     (wb_we),
        .wb_waddr  (wb_waddr),
        .wb_wdata  (wb_wdata),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
    );

    // si26 for b/bl, si16 otherwise, both in units of words
    assign br_offs = (br_kind == b || br_kind == bl)
                   ? {{4{id_inst[9]}}, id_inst[9:0], id_inst[25:10], 2'b00}
                   : {{14{id_inst[25]}}, id_inst[25:10], 2'b00};

    branch_unit branch_unit_i (
        .br_kind    (br_kind),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .pc         (id_pc),
        .imm_offs   (br_offs),
        .cond_taken (cond_taken),
        .target     (br_target)
    );

    assign br_taken = cond_taken & id_leave;  // one pulse as the branch moves on

    assign ex_alu_op       = alu_op;
    assign ex_alu_src1     = src1_is_pc ? id_pc : rj_value;
    assign ex_alu_src2     = src2_is_imm ? imm : rkd_value;
    assign ex_rkd_value    = rkd_value;  // store data
    assign ex_rf_we        = gr_we & id_valid;
    assign ex_rf_waddr     = dest;
    assign ex_res_from_mem = res_from_mem & id_valid;
    assign ex_mem_we       = mem_we & id_valid;
    assign ex_pc           = id_pc;

endmodule

/* hw/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  isa_pkg::inst_t      inst,
    output pipe_pkg::alu_op_t   alu_op,
    output isa_pkg::br_kind_t   br_kind,
    output pipe_pkg::word_t     imm,
    output logic                src1_is_pc,
    output logic                src2_is_imm,
    output pipe_pkg::reg_addr_t raddr1,
    output pipe_pkg::reg_addr_t raddr2,
    output logic                need_r1,
    output logic                need_r2,
    output pipe_pkg::reg_addr_t dest,
    output logic                gr_we,
    output logic                res_from_mem,
    output logic                mem_we
);
    import isa_pkg::*;
    import pipe_pkg::*;

    op31_26_t    op6;
    op25_22_t    op4;
    op21_20_t    op2;
    op19_15_t    op5;
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic        grp_alu, grp_reg, grp_shift;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and;
    logic        inst_or, inst_xor, inst_sll_w, inst_srl_w, inst_sra_w;
    logic        inst_slli_w, inst_srli_w, inst_srai_w;
    logic        inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic        inst_lu12i_w, inst_pcaddu12i, inst_ld_w, inst_st_w;
    logic        reg_alu, shift_imm, si12_alu, ui12_alu, upper_imm;
    logic        is_branch, cond_br, is_link, known;

    assign op6 = inst[31:26];
    assign op4 = inst[25:22];
    assign op2 = inst[21:20];
    assign op5 = inst[19:15];
    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];

    assign grp_alu   = op6 == op6_alu;
    assign grp_reg   = grp_alu && op4 == op4_reg && op2 == op2_reg;
    assign grp_shift = grp_alu && op4 == op4_shift && op2 == op2_shift;

    assign inst_add_w     = grp_reg && op5 == op5_add;
    assign inst_sub_w     = grp_reg && op5 == op5_sub;
    assign inst_slt       = grp_reg && op5 == op5_slt;
    assign inst_sltu      = grp_reg && op5 == op5_sltu;
    assign inst_nor       = grp_reg && op5 == op5_nor;
    assign inst_and       = grp_reg && op5 == op5_and;
    assign inst_or        = grp_reg && op5 == op5_or;
    assign inst_xor       = grp_reg && op5 == op5_xor;
    assign inst_sll_w     = grp_reg && op5 == op5_sll;
    assign inst_srl_w     = grp_reg && op5 == op5_srl;
    assign inst_sra_w     = grp_reg && op5 == op5_sra;
    assign inst_slli_w    = grp_shift && op5 == op5_slli;
    assign inst_srli_w    = grp_shift && op5 == op5_srli;
    assign inst_srai_w    = grp_shift && op5 == op5_srai;
    assign inst_addi_w    = grp_alu && op4 == op4_addi;
    assign inst_slti      = grp_alu && op4 == op4_slti;
    assign inst_sltui     = grp_alu && op4 == op4_sltui;
    assign inst_andi      = grp_alu && op4 == op4_andi;
    assign inst_ori       = grp_alu && op4 == op4_ori;
    assign inst_xori      = grp_alu && op4 == op4_xori;
    assign inst_lu12i_w   = op6 == op6_lu12i && !inst[25];
    assign inst_pcaddu12i = op6 == op6_pcaddu12i && !inst[25];
    assign inst_ld_w      = op6 == op6_mem && op4 == op4_ld_w;
    assign inst_st_w      = op6 == op6_mem && op4 == op4_st_w;

    // control flow is decoded from the top six bits alone
    always_comb begin
        case (op6)
            op6_jirl: br_kind = jirl;
            op6_b:    br_kind = b;
            op6_bl:   br_kind = bl;
            op6_beq:  br_kind = beq;
            op6_bne:  br_kind = bne;
            op6_blt:  br_kind = blt;
            op6_bge:  br_kind = bge;
            op6_bltu: br_kind = bltu;
            op6_bgeu: br_kind = bgeu;
            default:  br_kind = none;
        endcase
    end

    assign reg_alu   = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                     | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;
    assign shift_imm = inst_slli_w | inst_srli_w | inst_srai_w;
    assign si12_alu  = inst_addi_w | inst_slti | inst_sltui;
    assign ui12_alu  = inst_andi | inst_ori | inst_xori;
    assign upper_imm = inst_lu12i_w | inst_pcaddu12i;
    assign is_branch = br_kind != none;
    assign cond_br   = br_kind inside {beq, bne, blt, bge, bltu, bgeu};
    assign is_link   = br_kind == bl || br_kind == jirl;
    assign known     = reg_alu | shift_imm | si12_alu | ui12_alu | upper_imm
                     | inst_ld_w | inst_st_w | is_branch;

    always_comb begin
        alu_op = add;  // addi, address calc, link, pcaddu12i
        if (inst_sub_w) alu_op = sub;
        else if (inst_slt || inst_slti) alu_op = slt;
        else if (inst_sltu || inst_sltui) alu_op = sltu;
        else if (inst_and || inst_andi) alu_op = and_op;
        else if (inst_nor) alu_op = nor_op;
        else if (inst_or || inst_ori) alu_op = or_op;
        else if (inst_xor || inst_xori) alu_op = xor_op;
        else if (inst_sll_w || inst_slli_w) alu_op = sll;
        else if (inst_srl_w || inst_srli_w) alu_op = srl;
        else if (inst_sra_w || inst_srai_w) alu_op = sra;
        else if (inst_lu12i_w) alu_op = lui;
    end

    // ui5 sits in the low bits of i12, sign extension leaves it intact
    assign imm = is_link   ? link_offset :
                 upper_imm ? {i20, 12'b0} :
                 ui12_alu  ? {20'b0, i12} :
                             {{20{i12[11]}}, i12};

    assign src1_is_pc  = is_link | inst_pcaddu12i;
    assign src2_is_imm = shift_imm | si12_alu | ui12_alu | upper_imm
                       | inst_ld_w | inst_st_w | is_link;

    assign raddr1  = rj;
    assign raddr2  = (inst_st_w | cond_br) ? rd : rk;  // store data / compare operand
    assign need_r1 = known & ~(upper_imm | br_kind == b | br_kind == bl);
    assign need_r2 = reg_alu | cond_br | inst_st_w;

    assign dest         = (br_kind == bl) ? 5'd1 : rd;
    assign gr_we        = known & ~(inst_st_w | cond_br | br_kind == b);
    assign res_from_mem = inst_ld_w;
    assign mem_we       = inst_st_w;

endmodule

/* hw/isa_pkg.sv */
package isa_pkg;

    typedef logic [31:0] inst_t;

    // opcode fields, by bit range
    typedef logic [5:0] op31_26_t;
    typedef logic [3:0] op25_22_t;
    typedef logic [1:0] op21_20_t;
    typedef logic [4:0] op19_15_t;

    localparam op31_26_t op6_alu       = 6'h00;
    localparam op31_26_t op6_lu12i     = 6'h05;  // bit 25 must be 0
    localparam op31_26_t op6_pcaddu12i = 6'h07;  // bit 25 must be 0
    localparam op31_26_t op6_mem       = 6'h0a;
    localparam op31_26_t op6_jirl      = 6'h13;
    localparam op31_26_t op6_b         = 6'h14;
    localparam op31_26_t op6_bl        = 6'h15;
    localparam op31_26_t op6_beq       = 6'h16;
    localparam op31_26_t op6_bne       = 6'h17;
    localparam op31_26_t op6_blt       = 6'h18;
    localparam op31_26_t op6_bge       = 6'h19;
    localparam op31_26_t op6_bltu      = 6'h1a;
    localparam op31_26_t op6_bgeu      = 6'h1b;

    localparam op25_22_t op4_reg   = 4'h0;
    localparam op25_22_t op4_shift = 4'h1;
    localparam op25_22_t op4_ld_w  = 4'h2;  // under op6_mem
    localparam op25_22_t op4_st_w  = 4'h6;  // under op6_mem
    localparam op25_22_t op4_slti  = 4'h8;
    localparam op25_22_t op4_sltui = 4'h9;
    localparam op25_22_t op4_addi  = 4'ha;
    localparam op25_22_t op4_andi  = 4'hd;
    localparam op25_22_t op4_ori   = 4'he;
    localparam op25_22_t op4_xori  = 4'hf;

    localparam op21_20_t op2_shift = 2'h0;
    localparam op21_20_t op2_reg   = 2'h1;

    // three-register group
    localparam op19_15_t op5_add  = 5'h00;
    localparam op19_15_t op5_sub  = 5'h02;
    localparam op19_15_t op5_slt  = 5'h04;
    localparam op19_15_t op5_sltu = 5'h05;
    localparam op19_15_t op5_nor  = 5'h08;
    localparam op19_15_t op5_and  = 5'h09;
    localparam op19_15_t op5_or   = 5'h0a;
    localparam op19_15_t op5_xor  = 5'h0b;
    localparam op19_15_t op5_sll  = 5'h0e;
    localparam op19_15_t op5_srl  = 5'h0f;
    localparam op19_15_t op5_sra  = 5'h10;
    // shift-immediate group
    localparam op19_15_t op5_slli = 5'h01;
    localparam op19_15_t op5_srli = 5'h09;
    localparam op19_15_t op5_srai = 5'h11;

    typedef enum logic [3:0] {
        none, b, bl, jirl, beq, bne, blt, bge, bltu, bgeu
    } br_kind_t;

endpackage

/* hw/pipe_pkg.sv */
package pipe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        add,
        sub,
        slt,
        sltu,
        and_op,
        nor_op,
        or_op,
        xor_op,
        sll,
        srl,
        sra,
        lui     // passes src2 through
    } alu_op_t;

    localparam word_t link_offset = 32'd4;  // return address is pc + 4

endpackage

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  pipe_pkg::reg_addr_t raddr1,
    input  pipe_pkg::reg_addr_t raddr2,
    input  logic                we,
    input  pipe_pkg::reg_addr_t waddr,
    input  pipe_pkg::word_t     wdata,
    output pipe_pkg::word_t     rdata1,
    output pipe_pkg::word_t     rdata2
);
    import pipe_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* run.sh */
#!/bin/sh
# build and run the decode-stage testbench, then judge the log
(verilator --binary -j 0 --top-module tb_id_stage -o tb_id_stage -f flist.f \
    && ./obj_dir/tb_id_stage > sim.log 2>&1) || { echo "build or simulation failed"; exit 1; }
grep -q "Test failures found" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; } \
    || echo "simulation passed"

/* tests/tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int num_insts  = 600;
    localparam int max_cycles = 6 * num_insts + 100;

    logic clk = 1'b0;
    logic resetn, if_valid, id_allowin, ex_valid, ex_allowin;
    inst_t if_inst;
    word_t if_pc, ex_alu_src1, ex_alu_src2, ex_rkd_value, ex_pc, br_target;
    alu_op_t ex_alu_op;
    logic ex_rf_we, ex_res_from_mem, ex_mem_we, br_taken, flush;
    reg_addr_t ex_rf_waddr, fwd_ex_waddr, fwd_mem_waddr, wb_waddr;
    logic fwd_ex_we, fwd_ex_ready, fwd_mem_we, fwd_mem_ready, wb_we;
    word_t fwd_ex_wdata, fwd_mem_wdata, wb_wdata;

    int seed = 32'hb0ac7c02;
    int errors = 0;
    int cycles = 0;
    int left_count = 0;
    word_t mirror [32];
    logic m_valid = 1'b0;  // model of the held instruction
    inst_t m_inst;
    word_t m_pc;
    int m_kind, cur_kind;
    logic exp_leave, exp_taken, exp_allowin;

    id_stage id_stage_i (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: only %0d of %0d instructions left the stage, errors: %0d",
                     left_count, num_insts, errors);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic int unsigned rnd(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // kinds 0..32 are the kept instructions in table order and 33 is an unknown word
    function automatic inst_t encode(int k, reg_addr_t rd, reg_addr_t rj, reg_addr_t rk,
                                     logic [25:0] f);
        logic [4:0] op5 [14] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09, 5'h0a,
                                 5'h0b, 5'h0e, 5'h0f, 5'h10, 5'h01, 5'h09, 5'h11};
        logic [3:0] op4 [6] = '{4'ha, 4'h8, 4'h9, 4'hd, 4'he, 4'hf};
        logic [5:0] op6;
        op6 = 6'(k - 5);  // branch opcodes 0x13..0x1b for kinds 24..32
        if (k <= 10) return {6'h00, 4'h0, 2'h1, op5[k], rk, rj, rd};
        if (k <= 13) return {6'h00, 4'h1, 2'h0, op5[k], rk, rj, rd};
        if (k <= 19) return {6'h00, op4[k - 14], f[11:0], rj, rd};
        if (k == 20) return {6'h05, 1'b0, f[19:0], rd};
        if (k == 21) return {6'h07, 1'b0, f[19:0], rd};
        if (k == 22) return {6'h0a, 4'h2, f[11:0], rj, rd};
        if (k == 23) return {6'h0a, 4'h6, f[11:0], rj, rd};
        if (k == 25 || k == 26) return {op6, f[15:0], f[25:16]};
        if (k <= 32) return {op6, f[15:0], rj, rd};
        return {6'h3f, f};
    endfunction

    // newest writer first and the register mirror last
    function automatic word_t src_val(reg_addr_t a);
        if (a == 5'd0) return '0;
        if (fwd_ex_we && fwd_ex_waddr == a) return fwd_ex_wdata;
        if (fwd_mem_we && fwd_mem_waddr == a) return fwd_mem_wdata;
        if (wb_we && wb_waddr == a) return wb_wdata;
        return mirror[a];
    endfunction

    function automatic logic not_ready(reg_addr_t a);
        return a != 5'd0 && ((fwd_ex_we && fwd_ex_waddr == a && !fwd_ex_ready)
                          || (fwd_mem_we && fwd_mem_waddr == a && !fwd_mem_ready));
    endfunction

    task automatic check_val(input string name, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_outputs();
        int k;
        reg_addr_t rd, rj, r2;
        logic n1, n2, c1, c2, we, taken, stalled;
        word_t v1, v2, imm, offs;
        alu_op_t op;
        k = m_kind;
        rd = m_inst[4:0];
        rj = m_inst[9:5];
        r2 = (k == 23 || (k >= 27 && k <= 32)) ? rd : m_inst[14:10];
        n1 = k <= 19 || k == 22 || k == 23 || k == 24 || (k >= 27 && k <= 32);
        n2 = k <= 10 || k == 23 || (k >= 27 && k <= 32);
        v1 = src_val(rj);
        v2 = src_val(r2);
        stalled = (n1 && not_ready(rj)) || (n2 && not_ready(r2));
        exp_allowin = !m_valid || (ex_allowin && !stalled);
        exp_leave = m_valid && exp_allowin;
        if (k == 24 || k == 26) imm = 32'd4;
        else if (k == 20 || k == 21) imm = {m_inst[24:5], 12'h000};
        else if (k >= 17 && k <= 19) imm = {20'h0, m_inst[21:10]};
        else imm = {{20{m_inst[21]}}, m_inst[21:10]};
        case (k)
            1: op = sub;
            2, 15: op = slt;
            3, 16: op = sltu;
            4: op = nor_op;
            5, 17: op = and_op;
            6, 18: op = or_op;
            7, 19: op = xor_op;
            8, 11: op = sll;
            9, 12: op = srl;
            10, 13: op = sra;
            20: op = lui;
            default: op = add;
        endcase
        case (k)
            24, 25, 26: taken = 1'b1;
            27: taken = v1 == v2;
            28: taken = v1 != v2;
            29: taken = $signed(v1) < $signed(v2);
            30: taken = $signed(v1) >= $signed(v2);
            31: taken = v1 < v2;
            32: taken = v1 >= v2;
            default: taken = 1'b0;
        endcase
        if (k == 25 || k == 26) offs = {{4{m_inst[9]}}, m_inst[9:0], m_inst[25:10], 2'b00};
        else offs = {{14{m_inst[25]}}, m_inst[25:10], 2'b00};
        exp_taken = taken && exp_leave;
        we = m_valid && (k <= 22 || k == 24 || k == 26);
        c1 = n1 || k == 21 || k == 24 || k == 26;
        c2 = k <= 24 || k == 26;
        check_val("ex_valid", 32'(m_valid && !stalled), 32'(ex_valid));
        check_val("id_allowin", 32'(exp_allowin), 32'(id_allowin));
        check_val("br_taken", 32'(exp_taken), 32'(br_taken));
        check_val("ex_rf_we", 32'(we), 32'(ex_rf_we));
        check_val("ex_mem_we", 32'(m_valid && k == 23), 32'(ex_mem_we));
        check_val("ex_res_from_mem", 32'(m_valid && k == 22), 32'(ex_res_from_mem));
        if (m_valid) begin
            check_val("ex_pc", m_pc, ex_pc);
            if (c2) check_val("ex_alu_op", 32'(op), 32'(ex_alu_op));
            if (c1) check_val("ex_alu_src1", (k == 21 || k == 24 || k == 26) ? m_pc : v1,
                              ex_alu_src1);
            if (c2) check_val("ex_alu_src2", (k <= 10) ? v2 : imm, ex_alu_src2);
            if (n2) check_val("ex_rkd_value", v2, ex_rkd_value);
            if (we) check_val("ex_rf_waddr", 32'((k == 26) ? 5'd1 : rd), 32'(ex_rf_waddr));
            if (exp_taken) check_val("br_target", (k == 24 ? v1 : m_pc) + offs, br_target);
        end
    endtask

    task automatic drive_random();
        cur_kind = int'(rnd(34));
        if_valid = rnd(5) != 0;
        if_inst = encode(cur_kind, 5'(rnd(8)), 5'(rnd(8)), 5'(rnd(8)), 26'($random(seed)));
        if_pc = if_pc + 32'd4;  // every offer has its own pc
        ex_allowin = rnd(4) != 0;
        flush = rnd(32) == 0;
        fwd_ex_we = rnd(2) == 1;
        fwd_ex_waddr = 5'(rnd(8));
        fwd_ex_wdata = $random(seed);
        fwd_ex_ready = rnd(10) < 7;
        fwd_mem_we = rnd(2) == 1;
        fwd_mem_waddr = 5'(rnd(8));
        fwd_mem_wdata = $random(seed);
        fwd_mem_ready = rnd(10) < 7;
        wb_we = rnd(2) == 1;
        wb_waddr = 5'(rnd(8));
        wb_wdata = $random(seed);
    endtask

    initial begin
        resetn = 1'b0;
        {if_valid, ex_allowin, flush, fwd_ex_we, fwd_ex_ready} = '0;
        {fwd_mem_we, fwd_mem_ready, wb_we} = '0;
        if_inst = '0;
        if_pc = 32'h1c00_0000;
        {fwd_ex_waddr, fwd_mem_waddr, wb_waddr} = '0;
        {fwd_ex_wdata, fwd_mem_wdata, wb_wdata} = '0;
        mirror[0] = '0;
        m_kind = 33;
        for (int i = 1; i < 36; i++) begin
            @(posedge clk);
            #1;
            resetn = i >= 4;
            wb_we = i < 32;  // fill the register file with known values
            wb_waddr = 5'(i);
            wb_wdata = $random(seed);
            #5;
            check_val("ex_valid", '0, 32'(ex_valid));
            check_val("br_taken", '0, 32'(br_taken));
            check_val("ex_rf_we", '0, 32'(ex_rf_we));
            if (wb_we) mirror[wb_waddr] = wb_wdata;
        end
        while (left_count < num_insts) begin
            @(posedge clk);
            #1;
            drive_random();
            #5;
            compare_outputs();
            if (wb_we && wb_waddr != 5'd0) mirror[wb_waddr] = wb_wdata;
            if (exp_leave) left_count++;
            if (flush || exp_taken) begin
                m_valid = 1'b0;
            end else if (exp_allowin) begin
                m_valid = if_valid;
                m_inst = if_inst;
                m_pc = if_pc;
                m_kind = cur_kind;
            end
        end
        $display("%0d instructions checked, errors: %0d", left_count, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
